// ==== common/periph_pkg.sv ====
// peripheral subsystem package
// word type, timer control layout, register offsets and the address map
package periph_pkg;

    // data and address width, one word
    localparam int cpu_width = 32;

    // gpio pin count
    localparam int gpio_width = 8;

    // every address and data word on the register bus
    typedef logic [cpu_width-1:0] word_t;

    // timer control register, msb first
    // pending is cleared by writing 1 to it
    typedef struct packed {
        logic [28:0] reserved;
        logic        pending;
        logic        int_en;
        logic        enable;
    } timer_ctrl_t;

    // timer register offsets, addr bits 3:0
    localparam logic [3:0] reg_ctrl  = 4'h0;
    localparam logic [3:0] reg_count = 4'h4;
    localparam logic [3:0] reg_value = 4'h8;

    // gpio register offsets, addr bits 3:0
    localparam logic [3:0] reg_gpio_out = 4'h0;
    localparam logic [3:0] reg_gpio_in  = 4'h4;

    // region codes in addr bits 15:12
    localparam logic [3:0] sel_timer0 = 4'h0;
    localparam logic [3:0] sel_timer1 = 4'h1;
    localparam logic [3:0] sel_gpio   = 4'h2;

    // decoded slave, none for unmapped regions
    typedef enum logic [1:0] {
        timer0,
        timer1,
        gpio,
        none
    } slave_sel_e;

endpackage

// ==== common/periph_bus_if.sv ====
// core-to-slave register bus
// word address, write data and strobe out, combinational read data back
`timescale 1ns/1ps

interface periph_bus_if
    import periph_pkg::*;
();

    // full word address, slave looks at bits 3:0 only
    word_t addr;
    word_t wdata;
    // write on every clk edge while high
    logic  we;
    // valid in the same cycle as addr
    word_t rdata;

    // decoder side
    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    // register block side
    modport slave (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// ==== src/periph_decoder.sv ====
// peripheral address decoder
// picks a slave from addr bits 15:12, steers the write strobe
// and muxes read data back to the core
`timescale 1ns/1ps

module periph_decoder
    import periph_pkg::*;
(
    input  word_t           addr_i,
    input  word_t           data_i,
    input  logic            we_i,
    output word_t           data_o,
    periph_bus_if.master    t0_bus,
    periph_bus_if.master    t1_bus,
    periph_bus_if.master    gpio_bus
);

    slave_sel_e sel;

    // region decode
    always_comb begin
        case (addr_i[15:12])
            sel_timer0: sel = timer0;
            sel_timer1: sel = timer1;
            sel_gpio:   sel = gpio;
            // unmapped
            default:    sel = none;
        endcase
    end

    // address and data go to every slave
    assign t0_bus.addr    = addr_i;
    assign t0_bus.wdata   = data_i;
    assign t1_bus.addr    = addr_i;
    assign t1_bus.wdata   = data_i;
    assign gpio_bus.addr  = addr_i;
    assign gpio_bus.wdata = data_i;

    // strobe only toward the selected slave
    // writes to the none region are dropped here
    assign t0_bus.we   = we_i && (sel == timer0);
    assign t1_bus.we   = we_i && (sel == timer1);
    assign gpio_bus.we = we_i && (sel == gpio);

    // read return
    always_comb begin
        case (sel)
            timer0: begin
                data_o = t0_bus.rdata;
            end
            timer1: begin
                data_o = t1_bus.rdata;
            end
            gpio: begin
                data_o = gpio_bus.rdata;
            end
            default: begin
                // unmapped reads zero
                data_o = '0;
            end
        endcase
    end

endmodule

// ==== timer/timer.sv ====
// 32-bit count-up timer
// ctrl, count and expiry value registers on the register bus,
// level interrupt while pending and int_en are both set
`timescale 1ns/1ps

module timer
    import periph_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    periph_bus_if.slave    bus,
    output logic           int_sig_o
);

    // enable, int_en, pending (write 1 to clear)
    // reserved bits are never written and stay zero
    timer_ctrl_t timer_ctrl;

    // current count, read only
    word_t timer_count;

    // expiry value
    word_t timer_value;

    // write data seen through the ctrl layout
    timer_ctrl_t wr_ctrl;

    // count reached the expiry value while running
    logic count_hit;

    assign wr_ctrl   = timer_ctrl_t'(bus.wdata);
    assign count_hit = timer_ctrl.enable && (timer_count >= timer_value);

    // level interrupt
    assign int_sig_o = timer_ctrl.pending & timer_ctrl.int_en;

    // counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_count <= '0;
        end else begin
            if (!timer_ctrl.enable) begin
                // stopped, hold at zero
                timer_count <= '0;
            end else if (count_hit) begin
                // wrap at expiry
                timer_count <= '0;
            end else begin
                timer_count <= timer_count + word_t'(1);
            end
        end
    end

    // register writes and expiry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_ctrl  <= '0;
            timer_value <= '0;
        end else if (bus.we) begin
            // bus write wins, expiry in this cycle is skipped
            case (bus.addr[3:0])
                reg_ctrl: begin
                    timer_ctrl.enable  <= wr_ctrl.enable;
                    timer_ctrl.int_en  <= wr_ctrl.int_en;
                    // writing 1 clears pending
                    timer_ctrl.pending <= timer_ctrl.pending & ~wr_ctrl.pending;
                end
                reg_value: begin
                    timer_value <= bus.wdata;
                end
                default: begin
                    // count is read only, other offsets ignored
                end
            endcase
        end else if (count_hit) begin
            // one-shot, stop and flag
            timer_ctrl.enable  <= 1'b0;
            timer_ctrl.pending <= 1'b1;
        end
    end

    // register reads
    always_comb begin
        case (bus.addr[3:0])
            reg_ctrl:  bus.rdata = timer_ctrl;
            reg_count: bus.rdata = timer_count;
            reg_value: bus.rdata = timer_value;
            default:   bus.rdata = '0;
        endcase
    end

endmodule

// ==== src/gpio.sv ====
// gpio register block
// writable output register driving the pins,
// input pins through a two-flop synchronizer, both readable
`timescale 1ns/1ps

module gpio
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    periph_bus_if.slave           bus,
    input  logic [gpio_width-1:0] gpio_i,
    output logic [gpio_width-1:0] gpio_o
);

    // output register
    logic [gpio_width-1:0] gpio_out;

    // synchronizer stages, second one is the in register
    logic [gpio_width-1:0] gpio_in_meta;
    logic [gpio_width-1:0] gpio_in_sync;

    // pins follow the register one edge after the write
    assign gpio_o = gpio_out;

    // out register write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (bus.we && (bus.addr[3:0] == reg_gpio_out)) begin
            // upper data bits dropped
            gpio_out <= bus.wdata[gpio_width-1:0];
        end
    end

    // input sync, two edges from pin to register
    // in register is not writable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_in_meta <= '0;
            gpio_in_sync <= '0;
        end else begin
            gpio_in_meta <= gpio_i;
            gpio_in_sync <= gpio_in_meta;
        end
    end

    // reads, zero extended
    always_comb begin
        case (bus.addr[3:0])
            reg_gpio_out: begin
                bus.rdata = word_t'(gpio_out);
            end
            reg_gpio_in: begin
                bus.rdata = word_t'(gpio_in_sync);
            end
            default: begin
                bus.rdata = '0;
            end
        endcase
    end

endmodule

// ==== src/periph_subsys.sv ====
// peripheral subsystem top
// one core-side register port, decoder, two timers and a gpio block
// timer0 at 0x0000, timer1 at 0x1000, gpio at 0x2000
`timescale 1ns/1ps

module periph_subsys
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // core side
    input  word_t                 addr_i,
    input  word_t                 data_i,
    input  logic                  we_i,
    output word_t                 data_o,
    // interrupts
    output logic                  timer0_int_o,
    output logic                  timer1_int_o,
    // pins
    input  logic [gpio_width-1:0] gpio_i,
    output logic [gpio_width-1:0] gpio_o
);

    // one bus per slave
    periph_bus_if t0_if ();
    periph_bus_if t1_if ();
    periph_bus_if gpio_if ();

    periph_decoder u_decoder (
        .addr_i   (addr_i),
        .data_i   (data_i),
        .we_i     (we_i),
        .data_o   (data_o),
        .t0_bus   (t0_if.master),
        .t1_bus   (t1_if.master),
        .gpio_bus (gpio_if.master)
    );

    timer u_timer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (t0_if.slave),
        .int_sig_o (timer0_int_o)
    );

    timer u_timer1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (t1_if.slave),
        .int_sig_o (timer1_int_o)
    );

    gpio u_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (gpio_if.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

endmodule

// ==== tests/periph_subsys_asserts.sv ====
// timer assertions, bound into every timer instance
// interrupt level, reset behavior and one-shot expiry
`timescale 1ns/1ps

module periph_subsys_asserts
    import periph_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input timer_ctrl_t ctrl,
    input logic        count_hit,
    input logic        we,
    input logic        int_sig_o
);

    // unmasked expiry raises the interrupt on the next edge
    assert property (@(posedge clk) disable iff (!rst_n)
        (count_hit && !we && ctrl.int_en) |=> int_sig_o)
    else $error("timer interrupt did not rise after an unmasked expiry");

    // a reset edge leaves the interrupt low
    assert property (@(posedge clk) !rst_n |=> !int_sig_o)
    else $error("timer interrupt high after a reset edge");

    // expiry without a bus write stops the timer and flags pending
    assert property (@(posedge clk) disable iff (!rst_n)
        (count_hit && !we) |=> (!ctrl.enable && ctrl.pending))
    else $error("timer did not stop on expiry");

endmodule

bind timer periph_subsys_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (timer_ctrl),
    .count_hit (count_hit),
    .we        (bus.we),
    .int_sig_o (int_sig_o)
);

// ==== tests/tb_periph_subsys.sv ====
// testbench for the peripheral subsystem
// directed tests over the core-side register port, both timers and the gpio pins
`timescale 1ns/1ps

module tb_periph_subsys
    import periph_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    word_t                 addr_i;
    word_t                 data_i;
    logic                  we_i;
    word_t                 data_o;
    logic                  timer0_int_o;
    logic                  timer1_int_o;
    logic [gpio_width-1:0] gpio_i;
    logic [gpio_width-1:0] gpio_o;

    int checks;
    int errors;
    int timeouts;

    // 10 ns period
    initial clk = 1'b0;
    always #5 clk = ~clk;

    periph_subsys UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .we_i         (we_i),
        .data_o       (data_o),
        .timer0_int_o (timer0_int_o),
        .timer1_int_o (timer1_int_o),
        .gpio_i       (gpio_i),
        .gpio_o       (gpio_o)
    );

    // region in bits 15:12, offset in bits 3:0
    function automatic word_t reg_addr(input logic [3:0] region, input logic [3:0] offset);
        return {16'h0000, region, 8'h00, offset};
    endfunction

    // expected ctrl word, reserved bits zero
    function automatic word_t ctrl_word(input logic pending, input logic int_en,
                                        input logic enable);
        timer_ctrl_t c;
        c         = '0;
        c.pending = pending;
        c.int_en  = int_en;
        c.enable  = enable;
        return word_t'(c);
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // called at a falling edge, write lands on the next rising edge
    task automatic bus_write(input word_t addr, input word_t data);
        addr_i = addr;
        data_i = data;
        we_i   = 1'b1;
        @(negedge clk);
        we_i   = 1'b0;
    endtask

    // read data is combinational, sampled mid low phase
    task automatic bus_read(input word_t addr, output word_t data);
        addr_i = addr;
        we_i   = 1'b0;
        #1;
        data = data_o;
        @(negedge clk);
    endtask

    task automatic read_check(input string what, input word_t addr, input word_t exp);
        word_t rd;
        bus_read(addr, rd);
        check_word(what, rd, exp);
    endtask

    // falling edges until the interrupt is seen
    task automatic wait_int(input int which, input int max_cycles, output int edges);
        edges = 0;
        while (((which == 0) ? timer0_int_o : timer1_int_o) !== 1'b1 && edges < max_cycles) begin
            @(negedge clk);
            edges++;
        end
        if (((which == 0) ? timer0_int_o : timer1_int_o) !== 1'b1) begin
            timeouts++;
            $display("timeout: timer%0d interrupt did not rise within %0d cycles",
                     which, max_cycles);
        end
    endtask

    task automatic test_reset();
        read_check("t0 ctrl", reg_addr(sel_timer0, reg_ctrl), '0);
        read_check("t0 count", reg_addr(sel_timer0, reg_count), '0);
        read_check("t0 value", reg_addr(sel_timer0, reg_value), '0);
        read_check("t1 ctrl", reg_addr(sel_timer1, reg_ctrl), '0);
        read_check("t1 count", reg_addr(sel_timer1, reg_count), '0);
        read_check("t1 value", reg_addr(sel_timer1, reg_value), '0);
        read_check("gpio out", reg_addr(sel_gpio, reg_gpio_out), '0);
        read_check("gpio in", reg_addr(sel_gpio, reg_gpio_in), '0);
        check_bit("timer0 int", timer0_int_o, 1'b0);
        check_bit("timer1 int", timer1_int_o, 1'b0);
        check_word("gpio pins", word_t'(gpio_o), '0);
    endtask

    task automatic test_access();
        word_t w0;
        word_t w1;
        word_t wc;
        w0 = $urandom;
        w1 = $urandom;
        bus_write(reg_addr(sel_timer0, reg_value), w0);
        bus_write(reg_addr(sel_timer1, reg_value), w1);
        read_check("t0 value", reg_addr(sel_timer0, reg_value), w0);
        read_check("t1 value", reg_addr(sel_timer1, reg_value), w1);
        // huge expiry so a random enable cannot fire
        bus_write(reg_addr(sel_timer0, reg_value), '1);
        wc = $urandom;
        bus_write(reg_addr(sel_timer0, reg_ctrl), wc);
        read_check("t0 ctrl", reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b0, wc[1], wc[0]));
        bus_write(reg_addr(sel_timer0, reg_ctrl), '0);
        // count is read only, stopped timer holds zero
        bus_write(reg_addr(sel_timer0, reg_count), $urandom);
        read_check("t0 count", reg_addr(sel_timer0, reg_count), '0);
        // unmapped region
        bus_write(reg_addr(4'h3, reg_value), $urandom);
        read_check("unmapped 0x3008", reg_addr(4'h3, reg_value), '0);
        read_check("unmapped 0xf000", reg_addr(4'hf, reg_ctrl), '0);
        read_check("t0 value after drop", reg_addr(sel_timer0, reg_value), '1);
        read_check("t1 value after drop", reg_addr(sel_timer1, reg_value), w1);
    endtask

    task automatic test_expiry();
        word_t v;
        int    edges;
        v = word_t'($urandom_range(8, 1));
        bus_write(reg_addr(sel_timer0, reg_value), v);
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b0, 1'b1, 1'b1));
        // edges counted after the enabling write edge, interrupt up on edge v+1
        wait_int(0, 40, edges);
        check_word("t0 expiry edges", word_t'(edges), v + word_t'(1));
        read_check("t0 ctrl at expiry", reg_addr(sel_timer0, reg_ctrl),
                   ctrl_word(1'b1, 1'b1, 1'b0));
        read_check("t0 count at expiry", reg_addr(sel_timer0, reg_count), '0);
    endtask

    task automatic test_pending();
        word_t       rd;
        timer_ctrl_t c;
        int          n;
        // bit 2 clears pending, int_en kept
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b1, 1'b1, 1'b0));
        check_bit("timer0 int after clear", timer0_int_o, 1'b0);
        read_check("t0 ctrl after clear", reg_addr(sel_timer0, reg_ctrl),
                   ctrl_word(1'b0, 1'b1, 1'b0));
        // masked expiry
        bus_write(reg_addr(sel_timer0, reg_value), word_t'($urandom_range(8, 1)));
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b0, 1'b0, 1'b1));
        c = '0;
        n = 0;
        while (!c.pending && n < 40) begin
            check_bit("timer0 int masked", timer0_int_o, 1'b0);
            bus_read(reg_addr(sel_timer0, reg_ctrl), rd);
            c = timer_ctrl_t'(rd);
            n++;
        end
        if (!c.pending) begin
            timeouts++;
            $display("timeout: timer0 pending never set with the interrupt masked");
        end
        check_word("t0 ctrl masked expiry", rd, ctrl_word(1'b1, 1'b0, 1'b0));
        check_bit("timer0 int masked", timer0_int_o, 1'b0);
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        read_check("t0 ctrl cleared", reg_addr(sel_timer0, reg_ctrl), '0);
    endtask

    task automatic test_independence();
        word_t v0;
        word_t v1;
        int    e0;
        int    e1;
        int    n;
        v0 = word_t'($urandom_range(6, 2));
        v1 = v0 + word_t'($urandom_range(4, 1));
        bus_write(reg_addr(sel_timer0, reg_value), v0);
        bus_write(reg_addr(sel_timer1, reg_value), v1);
        // timer1 starts one edge after timer0
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b0, 1'b1, 1'b1));
        bus_write(reg_addr(sel_timer1, reg_ctrl), ctrl_word(1'b0, 1'b1, 1'b1));
        e0 = -1;
        e1 = -1;
        n  = 0;
        while ((e0 < 0 || e1 < 0) && n < 40) begin
            if (e0 < 0 && timer0_int_o === 1'b1) begin
                e0 = n;
                check_bit("timer1 int at timer0 expiry", timer1_int_o, 1'b0);
            end
            if (e1 < 0 && timer1_int_o === 1'b1) begin
                e1 = n;
            end
            if (e0 < 0 || e1 < 0) begin
                @(negedge clk);
                n++;
            end
        end
        if (e0 < 0 || e1 < 0) begin
            timeouts++;
            $display("timeout: both timer interrupts did not rise within 40 cycles");
        end
        check_word("t0 expiry edges", word_t'(e0), v0);
        check_word("t1 expiry edges", word_t'(e1), v1 + word_t'(1));
        read_check("t0 value", reg_addr(sel_timer0, reg_value), v0);
        read_check("t1 value", reg_addr(sel_timer1, reg_value), v1);
        read_check("t0 ctrl", reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b1, 1'b1, 1'b0));
        read_check("t1 ctrl", reg_addr(sel_timer1, reg_ctrl), ctrl_word(1'b1, 1'b1, 1'b0));
        bus_write(reg_addr(sel_timer0, reg_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        bus_write(reg_addr(sel_timer1, reg_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        check_bit("timer0 int cleared", timer0_int_o, 1'b0);
        check_bit("timer1 int cleared", timer1_int_o, 1'b0);
    endtask

    task automatic test_gpio();
        word_t                 w;
        logic [gpio_width-1:0] b;
        w = $urandom;
        bus_write(reg_addr(sel_gpio, reg_gpio_out), w);
        check_word("gpio pins", word_t'(gpio_o), word_t'(w[gpio_width-1:0]));
        read_check("gpio out", reg_addr(sel_gpio, reg_gpio_out), word_t'(w[gpio_width-1:0]));
        b      = $urandom;
        gpio_i = b;
        // two flop sync
        repeat (2) @(negedge clk);
        read_check("gpio in", reg_addr(sel_gpio, reg_gpio_in), word_t'(b));
        // in register ignores writes
        bus_write(reg_addr(sel_gpio, reg_gpio_in), ~word_t'(b));
        read_check("gpio in after write", reg_addr(sel_gpio, reg_gpio_in), word_t'(b));
    endtask

    initial begin
        void'($urandom(58));
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        addr_i   = '0;
        data_i   = '0;
        we_i     = 1'b0;
        gpio_i   = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_access();
        test_expiry();
        test_pending();
        test_independence();
        test_gpio();
        $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/periph_pkg.sv
common/periph_bus_if.sv
src/periph_decoder.sv
timer/timer.sv
src/gpio.sv
src/periph_subsys.sv
tests/periph_subsys_asserts.sv
tests/tb_periph_subsys.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  # shared package and bus interface
  - files:
      - common/periph_pkg.sv
      - common/periph_bus_if.sv
  # design
  - files:
      - src/periph_decoder.sv
      - timer/timer.sv
      - src/gpio.sv
      - src/periph_subsys.sv
  # testbench and bound assertions
  - target: test
    files:
      - tests/periph_subsys_asserts.sv
      - tests/tb_periph_subsys.sv
